/* build.f */
common/frame_pkg.sv
logic/frame_position.sv
logic/sof_tracker.sv
overhead/overhead_extract.sv
overhead/overhead_regs.sv
logic/frame_disassembler.sv
bench/tb_frame_disassembler.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps -f build.f \
    --top-module tb_frame_disassembler -Mdir obj_dir -o tb_sim &&
{ out="$(./obj_dir/tb_sim)"; printf '%s\n' "$out"; } &&
printf '%s\n' "$out" | grep -qx "PASS: all tests" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

/* bench/tb_frame_disassembler.sv */
/*
 * Frame disassembler testbench
 * Sends generated frames from a test table and checks overhead
 * extraction, resync reporting and the APB registers
 */
`default_nettype none

module tb_frame_disassembler
    import frame_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [7:0]  frames;
        logic [15:0] bad_offset;    // 0 means no misplaced start
        logic [7:0]  gap_pct;
        logic        capture;
        logic        exp_resync;
    } test_row_t;

    localparam int NUM_TESTS = 5;
    localparam test_row_t TESTS [NUM_TESTS] = '{
        '{8'd2, 16'd0,   8'd0,  1'b1, 1'b0},
        '{8'd2, 16'd0,   8'd25, 1'b1, 1'b0},
        '{8'd2, 16'd300, 8'd10, 1'b1, 1'b1},
        '{8'd1, 16'd0,   8'd15, 1'b0, 1'b0},
        '{8'd1, 16'd0,   8'd0,  1'b1, 1'b0}
    };

    logic                   i_clock;
    logic                   i_reset;
    logic [NB_DATA-1:0]     i_data;
    logic                   i_valid;
    logic                   i_sof;
    logic                   i_psel;
    logic                   i_penable;
    logic                   i_pwrite;
    logic [NB_APB_ADDR-1:0] i_paddr;
    logic [NB_APB_DATA-1:0] i_pwdata;
    logic [NB_APB_DATA-1:0] o_prdata;
    logic                   o_pready;
    logic                   o_pslverr;
    logic                   o_encr_oh_rdy;
    logic                   o_resync;

    integer seed = 32'hb9d8;
    int     errors = 0;
    int     checks = 0;
    int     resync_count = 0;
    int     cycle_count = 0;
    int     frame_idx = 0;
    int     pos_col = 0;
    int     pos_row = 0;

    // Last values the registers should hold
    logic [NB_QUARTER-1:0]  exp_encr;
    logic [NB_ROW-1:0]      exp_encr_row;
    logic [NB_FRAME_OH-1:0] exp_foh;

    frame_disassembler uut (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_data        (i_data),
        .i_valid       (i_valid),
        .i_sof         (i_sof),
        .i_psel        (i_psel),
        .i_penable     (i_penable),
        .i_pwrite      (i_pwrite),
        .i_paddr       (i_paddr),
        .i_pwdata      (i_pwdata),
        .o_prdata      (o_prdata),
        .o_pready      (o_pready),
        .o_pslverr     (o_pslverr),
        .o_encr_oh_rdy (o_encr_oh_rdy),
        .o_resync      (o_resync)
    );

    initial
    begin
        i_clock = 1'b0;
        forever #5 i_clock = ~i_clock;
    end

    // Registered pulse, stable at the falling edge
    always @(negedge i_clock)
    begin
        if (o_resync)
            resync_count++;
    end

    initial
    begin : timeout
        int limit;
        limit = 1000;
        for (int t = 0; t < NUM_TESTS; t++)
            limit += int'(TESTS[t].frames) * int'(FRAME_WORDS) * 4;
        while (cycle_count < limit)
        begin
            @(posedge i_clock);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("FAIL: see errors above");
        $finish;
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        checks++;
        assert (got === expected)
        else
        begin
            errors++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, expected);
        end
    endtask

    // Each quarter carries its frame, row, column and index
    function automatic logic [NB_QUARTER-1:0] quarter_value(input int frame, input int r,
                                                            input int c, input int q);
        return {8'hc3, 8'(q), 16'(frame), 8'(r), 8'(c), 16'h5a96};
    endfunction

    // Quarter 3 sits in the top bits of the word
    function automatic data_word_t make_word(input int frame, input int r, input int c);
        logic [NB_DATA-1:0] bits;
        for (int q = 0; q < 4; q++)
            bits[q*NB_QUARTER +: NB_QUARTER] = quarter_value(frame, r, c, q);
        return bits;
    endfunction

    //**************************************************************************
    // APB transfers, setup then access, one idle cycle after
    //**************************************************************************
    task automatic apb_read(input logic [NB_APB_ADDR-1:0] addr,
                            output logic [NB_APB_DATA-1:0] data, output logic err);
        @(negedge i_clock);
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
        i_paddr   = addr;
        @(negedge i_clock);
        i_penable = 1'b1;
        #1;
        data = o_prdata;
        err  = o_pslverr;
        check_value("o_pready", 64'(o_pready), 64'd1);
        @(negedge i_clock);
        i_psel    = 1'b0;
        i_penable = 1'b0;
    endtask

    task automatic apb_write(input logic [NB_APB_ADDR-1:0] addr,
                             input logic [NB_APB_DATA-1:0] data);
        @(negedge i_clock);
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = 1'b1;
        i_paddr   = addr;
        i_pwdata  = data;
        @(negedge i_clock);
        i_penable = 1'b1;
        #1;
        check_value("o_pslverr", 64'(o_pslverr), 64'd0);
        @(negedge i_clock);
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
    endtask

    task automatic read_check(input logic [NB_APB_ADDR-1:0] addr, input string name,
                              input logic [NB_APB_DATA-1:0] mask,
                              input logic [NB_APB_DATA-1:0] expected);
        logic [NB_APB_DATA-1:0] data;
        logic                   err;
        apb_read(addr, data, err);
        check_value("o_pslverr", 64'(err), 64'd0);
        check_value(name, 64'(data & mask), 64'(expected & mask));
    endtask

    //**************************************************************************
    // Stream driver with a position model of its own
    //**************************************************************************
    task automatic idle_cycle();
        @(negedge i_clock);
        i_valid = 1'b0;
        i_sof   = 1'b0;
        #1;
        check_value("o_encr_oh_rdy", 64'(o_encr_oh_rdy), 64'd0);
    endtask

    task automatic send_word(input logic sof, input logic capture);
        data_word_t w;
        logic       odd;
        logic       at_encr;
        logic       at_end;
        if (sof)
        begin
            pos_col = 0;
            pos_row = 0;
        end
        w       = make_word(frame_idx, pos_row, pos_col);
        odd     = (pos_row % 2 == 1);
        at_encr = (pos_col == 118);
        at_end  = (pos_col == (odd ? 127 : 126));
        @(negedge i_clock);
        i_valid = 1'b1;
        i_sof   = sof;
        i_data  = w;
        #1;
        check_value("o_encr_oh_rdy", 64'(o_encr_oh_rdy), 64'(capture && at_encr));
        if (capture && at_encr)
        begin
            exp_encr     = quarter_value(frame_idx, pos_row, pos_col, odd ? 0 : 2);
            exp_encr_row = 2'(pos_row);
        end
        if (capture && at_end)
        begin
            if (odd)
                exp_foh = {quarter_value(frame_idx, pos_row, pos_col, 3),
                           quarter_value(frame_idx, pos_row, pos_col, 2)};
            else
                exp_foh = {quarter_value(frame_idx, pos_row, pos_col, 1),
                           quarter_value(frame_idx, pos_row, pos_col, 0)};
        end
        if (at_end)
        begin
            pos_col = 0;
            pos_row = (pos_row + 1) % 4;
        end
        else
            pos_col++;
        // Pause the stream to read back what was just captured
        if (at_encr)
        begin
            idle_cycle();
            read_check(ADDR_ENCR_LO, "encr_oh[31:0]", '1, exp_encr[31:0]);
            read_check(ADDR_ENCR_HI, "encr_oh[63:32]", '1, exp_encr[63:32]);
            read_check(ADDR_STATUS, "status row", 32'h30, {26'd0, exp_encr_row, 4'd0});
        end
        if (at_end)
        begin
            idle_cycle();
            read_check(ADDR_FOH0, "frame_oh[31:0]", '1, exp_foh[31:0]);
            read_check(ADDR_FOH1, "frame_oh[63:32]", '1, exp_foh[63:32]);
            read_check(ADDR_FOH2, "frame_oh[95:64]", '1, exp_foh[95:64]);
            read_check(ADDR_FOH3, "frame_oh[127:96]", '1, exp_foh[127:96]);
        end
    endtask

    task automatic send_frames(input test_row_t t);
        int draw;
        for (int f = 0; f < int'(t.frames); f++)
        begin
            for (int n = 0; n < int'(FRAME_WORDS); n++)
            begin
                draw = int'($unsigned($random(seed)) % 32'd100);
                if (draw < int'(t.gap_pct))
                    idle_cycle();
                send_word(n == 0 || (f == 0 && n == int'(t.bad_offset)), t.capture);
            end
            frame_idx++;
        end
        idle_cycle();
    endtask

    initial
    begin : main
        logic [NB_APB_DATA-1:0] data;
        logic                   err;
        int                     resync_start;
        i_reset   = 1'b1;
        i_data    = '0;
        i_valid   = 1'b0;
        i_sof     = 1'b0;
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
        i_paddr   = '0;
        i_pwdata  = '0;
        repeat (4) @(negedge i_clock);
        i_reset = 1'b0;

        // Reset values, capture on and no lock or resync yet
        read_check(ADDR_CTRL, "ctrl", '1, 32'h1);
        read_check(ADDR_STATUS, "status[1:0]", 32'h3, 32'h0);

        for (int t = 0; t < NUM_TESTS; t++)
        begin
            apb_write(ADDR_CTRL, 32'(TESTS[t].capture));
            read_check(ADDR_CTRL, "ctrl", '1, 32'(TESTS[t].capture));
            resync_start = resync_count;
            send_frames(TESTS[t]);
            check_value("resync pulses", 64'(resync_count - resync_start),
                        64'(TESTS[t].exp_resync));
            read_check(ADDR_STATUS, "status[1:0]", 32'h3, {30'd0, 1'b1, TESTS[t].exp_resync});
            if (TESTS[t].exp_resync)
            begin
                // Read-only bits must not move on this write
                apb_write(ADDR_STATUS, 32'h33);
                read_check(ADDR_STATUS, "status", 32'h33, {26'd0, exp_encr_row, 4'b0010});
            end
        end

        // Unmapped address
        apb_read(8'h20, data, err);
        check_value("o_pslverr", 64'(err), 64'd1);
        check_value("o_prdata", 64'(data), 64'd0);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

/* logic/frame_disassembler.sv */
/*
 * Frame disassembler front end
 * Tracks frame position and start, extracts the overheads and
 * exposes them over APB
 */
`default_nettype none

module frame_disassembler
    import frame_pkg::*;
(
    input  wire logic                   i_clock,
    input  wire logic                   i_reset,
    input  wire logic [NB_DATA-1:0]     i_data,
    input  wire logic                   i_valid,
    input  wire logic                   i_sof,
    input  wire logic                   i_psel,
    input  wire logic                   i_penable,
    input  wire logic                   i_pwrite,
    input  wire logic [NB_APB_ADDR-1:0] i_paddr,
    input  wire logic [NB_APB_DATA-1:0] i_pwdata,
    output logic [NB_APB_DATA-1:0]      o_prdata,
    output logic                        o_pready,
    output logic                        o_pslverr,
    output logic                        o_encr_oh_rdy,
    output logic                        o_resync
);

    logic [NB_COL-1:0]      col;
    logic [NB_ROW-1:0]      row;
    logic                   row_end;
    logic                   locked;
    logic                   resync;
    logic                   capture_en;
    logic                   encr_oh_rdy;
    logic [NB_QUARTER-1:0]  encr_oh;
    logic [NB_ROW-1:0]      encr_row;
    logic [NB_FRAME_OH-1:0] frame_oh;
    logic                   frame_oh_stb;

    frame_position u_position (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_valid   (i_valid),
        .i_sof     (i_sof),
        .o_col     (col),
        .o_row     (row),
        .o_row_end (row_end)
    );

    sof_tracker u_sof_tracker (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_valid        (i_valid),
        .i_sof          (i_sof),
        .o_locked       (locked),
        .o_resync_pulse (resync)
    );

    overhead_extract u_extract (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_valid        (i_valid),
        .i_data         (i_data),
        .i_col          (col),
        .i_row          (row),
        .i_row_end      (row_end),
        .i_capture_en   (capture_en),
        .o_encr_oh_rdy  (encr_oh_rdy),
        .o_encr_oh      (encr_oh),
        .o_encr_row     (encr_row),
        .o_frame_oh     (frame_oh),
        .o_frame_oh_stb (frame_oh_stb)
    );

    overhead_regs u_regs (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_psel         (i_psel),
        .i_penable      (i_penable),
        .i_pwrite       (i_pwrite),
        .i_paddr        (i_paddr),
        .i_pwdata       (i_pwdata),
        .i_resync_pulse (resync),
        .i_locked       (locked),
        .i_encr_oh_stb  (encr_oh_rdy),
        .i_encr_oh      (encr_oh),
        .i_encr_row     (encr_row),
        .i_frame_oh_stb (frame_oh_stb),
        .i_frame_oh     (frame_oh),
        .o_prdata       (o_prdata),
        .o_pready       (o_pready),
        .o_pslverr      (o_pslverr),
        .o_capture_en   (capture_en)
    );

    assign o_encr_oh_rdy = encr_oh_rdy;
    assign o_resync      = resync;

endmodule

`default_nettype wire

/* overhead/overhead_regs.sv */
/*
 * APB register block
 * Capture control, resync and lock status, and the last captured
 * encryption and frame overheads
 */
`default_nettype none

module overhead_regs
    import frame_pkg::*;
(
    input  wire logic                   i_clock,
    input  wire logic                   i_reset,
    input  wire logic                   i_psel,
    input  wire logic                   i_penable,
    input  wire logic                   i_pwrite,
    input  wire logic [NB_APB_ADDR-1:0] i_paddr,
    input  wire logic [NB_APB_DATA-1:0] i_pwdata,
    input  wire logic                   i_resync_pulse,
    input  wire logic                   i_locked,
    input  wire logic                   i_encr_oh_stb,
    input  wire logic [NB_QUARTER-1:0]  i_encr_oh,
    input  wire logic [NB_ROW-1:0]      i_encr_row,
    input  wire logic                   i_frame_oh_stb,
    input  wire logic [NB_FRAME_OH-1:0] i_frame_oh,
    output logic [NB_APB_DATA-1:0]      o_prdata,
    output logic                        o_pready,
    output logic                        o_pslverr,
    output logic                        o_capture_en
);

    logic                   access;
    logic                   addr_hit;
    logic [NB_APB_DATA-1:0] rd_word;
    logic                   capture_en;
    logic                   resync_flag;
    logic                   encr_stb_q;
    logic [NB_QUARTER-1:0]  encr_oh_q;
    logic [NB_ROW-1:0]      encr_row_q;
    logic [NB_FRAME_OH-1:0] frame_oh_q;

    assign access = i_psel && i_penable;

    //**************************************************************************
    // Control and status
    //**************************************************************************
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            capture_en <= 1'b1;
        else if (access && i_pwrite && (i_paddr == ADDR_CTRL))
            capture_en <= i_pwdata[0];
    end

    // Sticky, a new resync wins over a clear
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            resync_flag <= 1'b0;
        else if (i_resync_pulse)
            resync_flag <= 1'b1;
        else if (access && i_pwrite && (i_paddr == ADDR_STATUS) && i_pwdata[0])
            resync_flag <= 1'b0;
    end

    // Extractor data lands one clock after its ready pulse
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            encr_stb_q <= 1'b0;
        else
            encr_stb_q <= i_encr_oh_stb;
    end

    always_ff @(posedge i_clock)
    begin
        if (encr_stb_q)
        begin
            encr_oh_q  <= i_encr_oh;
            encr_row_q <= i_encr_row;
        end
        if (i_frame_oh_stb)
            frame_oh_q <= i_frame_oh;
    end

    //**************************************************************************
    // Read decode
    //**************************************************************************
    always_comb
    begin
        addr_hit = 1'b1;
        case (i_paddr)
            ADDR_CTRL:    rd_word = {{(NB_APB_DATA-1){1'b0}}, capture_en};
            ADDR_STATUS:  rd_word = {{(NB_APB_DATA-6){1'b0}}, encr_row_q, 2'b00,
                                     i_locked, resync_flag};
            ADDR_ENCR_LO: rd_word = encr_oh_q[0 +: NB_APB_DATA];
            ADDR_ENCR_HI: rd_word = encr_oh_q[NB_APB_DATA +: NB_APB_DATA];
            ADDR_FOH0:    rd_word = frame_oh_q[0 +: NB_APB_DATA];
            ADDR_FOH1:    rd_word = frame_oh_q[NB_APB_DATA +: NB_APB_DATA];
            ADDR_FOH2:    rd_word = frame_oh_q[2*NB_APB_DATA +: NB_APB_DATA];
            ADDR_FOH3:    rd_word = frame_oh_q[3*NB_APB_DATA +: NB_APB_DATA];
            default:
            begin
                addr_hit = 1'b0;
                rd_word  = '0;
            end
        endcase
    end

    assign o_prdata     = (access && !i_pwrite) ? rd_word : '0;
    assign o_pready     = 1'b1;
    assign o_pslverr    = access && !addr_hit;
    assign o_capture_en = capture_en;

endmodule

`default_nettype wire

/* overhead/overhead_extract.sv */
/*
 * Overhead extractor
 * Picks the encryption overhead at column 118 and the frame
 * overhead at each row end out of the input word
 */
`default_nettype none

module overhead_extract
    import frame_pkg::*;
(
    input  wire logic                   i_clock,
    input  wire logic                   i_reset,
    input  wire logic                   i_valid,
    input  wire logic [NB_DATA-1:0]     i_data,
    input  wire logic [NB_COL-1:0]      i_col,
    input  wire logic [NB_ROW-1:0]      i_row,
    input  wire logic                   i_row_end,
    input  wire logic                   i_capture_en,
    output logic                        o_encr_oh_rdy,
    output logic [NB_QUARTER-1:0]       o_encr_oh,
    output logic [NB_ROW-1:0]           o_encr_row,
    output logic [NB_FRAME_OH-1:0]      o_frame_oh,
    output logic                        o_frame_oh_stb
);

    data_word_t word;
    logic       encr_hit;
    logic       foh_hit;

    assign word     = i_data;
    assign encr_hit = i_valid && i_capture_en && (i_col == ENCR_OH_COL);
    assign foh_hit  = i_valid && i_capture_en && i_row_end;

    assign o_encr_oh_rdy = encr_hit;

    // Even rows carry it in quarter 2, odd rows in quarter 0
    always_ff @(posedge i_clock)
    begin
        if (encr_hit)
        begin
            o_encr_oh  <= i_row[0] ? word.quarters[0] : word.quarters[2];
            o_encr_row <= i_row;
        end
    end

    //**************************************************************************
    // Frame overhead, upper half on odd rows
    //**************************************************************************
    always_ff @(posedge i_clock)
    begin
        if (foh_hit)
            o_frame_oh <= i_row[0] ? word.halves[1] : word.halves[0];
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            o_frame_oh_stb <= 1'b0;
        else
            o_frame_oh_stb <= foh_hit;
    end

endmodule

`default_nettype wire

/* logic/sof_tracker.sv */
/*
 * Frame start tracker
 * Locks on the first frame start, predicts the following ones and
 * flags a resync when the stream disagrees with the prediction
 */
`default_nettype none

module sof_tracker
    import frame_pkg::*;
(
    input  wire logic i_clock,
    input  wire logic i_reset,
    input  wire logic i_valid,
    input  wire logic i_sof,
    output logic      o_locked,
    output logic      o_resync_pulse
);

    logic                    locked;
    logic [NB_FRAME_CNT-1:0] word_cnt;
    logic                    predict_sof;
    logic                    resync;
    logic                    resync_q;

    // Word index inside the frame, 0 is the expected start
    assign predict_sof = (word_cnt == '0);

    // Decided on the disagreeing word itself
    assign resync = i_valid && locked && (i_sof != predict_sof);

    //**************************************************************************
    // Lock state
    //**************************************************************************
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            locked <= 1'b0;
        end
        else if (i_valid)
        begin
            if (resync)
                locked <= 1'b0;
            else if (!locked && i_sof)
                locked <= 1'b1;
        end
    end

    // Predictor, restarts behind each accepted start
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            word_cnt <= '0;
        end
        else if (i_valid)
        begin
            if (!locked)
                word_cnt <= NB_FRAME_CNT'(1);
            else if (word_cnt == FRAME_WORDS - 1'b1)
                word_cnt <= '0;
            else
                word_cnt <= word_cnt + 1'b1;
        end
    end

    // Pulse leaves one clock after the word
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            resync_q <= 1'b0;
        else
            resync_q <= resync;
    end

    assign o_locked       = locked;
    assign o_resync_pulse = resync_q;

endmodule

`default_nettype wire

/* logic/frame_position.sv */
/*
 * Frame position tracker
 * Counts column and row of each valid word, with row lengths
 * alternating between 127 and 128 words
 */
`default_nettype none

module frame_position
    import frame_pkg::*;
(
    input  wire logic              i_clock,
    input  wire logic              i_reset,
    input  wire logic              i_valid,
    input  wire logic              i_sof,
    output logic [NB_COL-1:0]      o_col,
    output logic [NB_ROW-1:0]      o_row,
    output logic                   o_row_end
);

    logic [NB_COL-1:0] col_q;
    logic [NB_ROW-1:0] row_q;
    logic [NB_COL-1:0] cur_col;
    logic [NB_ROW-1:0] cur_row;
    logic [NB_COL-1:0] col_last;
    logic              row_end;

    // A frame start forces the current word to column 0 of row 0
    always_comb
    begin
        if (i_valid && i_sof)
        begin
            cur_col = '0;
            cur_row = '0;
        end
        else
        begin
            cur_col = col_q;
            cur_row = row_q;
        end
    end

    // Even rows are short, odd rows long
    assign col_last = cur_row[0] ? COL_LAST_LONG : COL_LAST_SHORT;
    assign row_end  = (cur_col == col_last);

    //**************************************************************************
    // Counters
    //**************************************************************************
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            col_q <= '0;
            row_q <= '0;
        end
        else if (i_valid)
        begin
            if (row_end)
            begin
                col_q <= '0;
                // Wraps after row 3 by width
                row_q <= cur_row + 1'b1;
            end
            else
            begin
                col_q <= cur_col + 1'b1;
                row_q <= cur_row;
            end
        end
    end

    assign o_col     = cur_col;
    assign o_row     = cur_row;
    assign o_row_end = row_end;

endmodule

`default_nettype wire

/* common/frame_pkg.sv */
/*
 * Frame disassembler shared definitions
 * Frame geometry, APB register map and the data word views
 */
`default_nettype none

package frame_pkg;

    // Data path widths
    localparam int NB_DATA      = 256;
    localparam int NB_QUARTER   = 64;
    localparam int NB_FRAME_OH  = 128;

    // Frame geometry, four rows alternating 127 and 128 words
    localparam int NB_COL       = 8;
    localparam int NB_ROW       = 2;
    localparam int NB_FRAME_CNT = 9;

    localparam logic [NB_COL-1:0]       COL_LAST_SHORT = 8'd126;
    localparam logic [NB_COL-1:0]       COL_LAST_LONG  = 8'd127;
    localparam logic [NB_COL-1:0]       ENCR_OH_COL    = 8'd118;
    localparam logic [NB_FRAME_CNT-1:0] FRAME_WORDS    = 9'd510;

    //**************************************************************************
    // APB register map
    //**************************************************************************
    localparam int NB_APB_ADDR  = 8;
    localparam int NB_APB_DATA  = 32;

    localparam logic [NB_APB_ADDR-1:0] ADDR_CTRL    = 8'h00;
    localparam logic [NB_APB_ADDR-1:0] ADDR_STATUS  = 8'h04;
    localparam logic [NB_APB_ADDR-1:0] ADDR_ENCR_LO = 8'h08;
    localparam logic [NB_APB_ADDR-1:0] ADDR_ENCR_HI = 8'h0C;
    localparam logic [NB_APB_ADDR-1:0] ADDR_FOH0    = 8'h10;
    localparam logic [NB_APB_ADDR-1:0] ADDR_FOH1    = 8'h14;
    localparam logic [NB_APB_ADDR-1:0] ADDR_FOH2    = 8'h18;
    localparam logic [NB_APB_ADDR-1:0] ADDR_FOH3    = 8'h1C;

    // One input word, read as quarters at the overhead column
    // and as halves at the row end
    typedef union packed {
        logic [3:0][NB_QUARTER-1:0]  quarters;
        logic [1:0][NB_FRAME_OH-1:0] halves;
    } data_word_t;

endpackage

`default_nettype wire
